/* bus_patterns.hex */
// mode addr count byte0 byte1 byte2 byte3 mask
// mode bit 0 selects I3C, bit 4 ends with repeated START; mask bit n corrupts T-bit n
00 50 03 11 22 33 00 00
00 33 02 AA BB 00 00 00
10 50 02 C4 7F 00 00 00
00 50 01 9C 00 00 00 00
01 2A 04 01 02 03 04 00
01 2A 03 A5 5A C3 00 02
01 2A 02 66 99 00 00 02
01 7E 02 DE AD 00 00 00
01 50 02 12 34 00 00 00
00 2A 02 56 78 00 00 00
11 2A 02 E1 E2 00 00 00
01 2A 01 0F 00 00 00 00

/* flist.f */
i3c_pkg.sv
controller_pkg.sv
bus_monitor.sv
i2c_target_engine.sv
i3c_target_engine.sv
controller_standby.sv
rx_queue.sv
i3c_target_top.sv
tb_i3c_target_assertions.sv
tb_i3c_target.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_i3c_target
FLIST     ?= flist.f
LOG       ?= sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_i3c_target.sv */
// Testbench: bus controller model, pattern-driven stimulus, RX queue checks, watchdog
`timescale 1ns/1ps

module tb_i3c_target
  import i3c_pkg::*;
  import controller_pkg::*;
();

  localparam int NumPatterns     = 12;
  localparam int WordsPerPattern = 8;
  localparam int MaxBytes        = 4;
  localparam int HalfClocks      = 8;
  localparam int BitCycles       = 2 * HalfClocks + 2;
  localparam int LongestCycles   = ((MaxBytes + 1) * 9 + 4) * BitCycles + 64;
  localparam int TimeoutNs       = NumPatterns * LongestCycles * 2 * 40 + 16 * 40;
  localparam addr7_t StaticAddr  = 7'h50;
  localparam addr7_t DynAddr     = 7'h2A;

  logic       clk_i, arst_n_i;
  logic       scl_drv, sda_drv, sda_line;
  logic       i3c_en_i, dyn_addr_valid_i, rx_rready_i;
  addr7_t     static_addr_i, dyn_addr_i;
  logic       sda_o, bus_start_o, bus_rstart_o, bus_stop_o;
  logic [7:0] bus_addr_o;
  logic       bus_addr_valid_o, parity_err_o, rx_rvalid_o;
  rx_entry_t  rx_rentry_o;

  logic [7:0] pat_mem [NumPatterns * WordsPerPattern];
  rx_entry_t  exp_q [$];
  logic [31:0] lcg_state;
  logic [7:0] last_addr;
  int start_cnt, rstart_cnt, stop_cnt, perr_cnt, addr_cnt;
  int exp_start, exp_rstart, exp_stop, exp_perr, exp_addr;
  logic bus_open;

  // Open-drain SDA: either side can pull low
  assign sda_line = sda_drv & sda_o;

  i3c_target_top #(
    .RxQueueDepth(16),
    .SyncStages  (2)
  ) UUT (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .scl_i           (scl_drv),
    .sda_i           (sda_line),
    .i3c_en_i        (i3c_en_i),
    .static_addr_i   (static_addr_i),
    .dyn_addr_i      (dyn_addr_i),
    .dyn_addr_valid_i(dyn_addr_valid_i),
    .sda_o           (sda_o),
    .bus_start_o     (bus_start_o),
    .bus_rstart_o    (bus_rstart_o),
    .bus_stop_o      (bus_stop_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .parity_err_o    (parity_err_o),
    .rx_rvalid_o     (rx_rvalid_o),
    .rx_rentry_o     (rx_rentry_o),
    .rx_rready_i     (rx_rready_i)
  );

  bind i3c_target_top tb_i3c_target_assertions xassertions (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .i3c_en_i    (i3c_en_i),
    .sda_o       (sda_o),
    .parity_err_o(parity_err_o),
    .rx_rvalid_o (rx_rvalid_o),
    .rx_rready_i (rx_rready_i),
    .rx_rentry_o (rx_rentry_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_entry(input rx_entry_t got, input rx_entry_t exp);
    if (got !== exp) begin
      $display("Mismatch rx_rentry_o: got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch bus_addr_o: got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch %s count: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic half_wait();
    repeat (HalfClocks) @(negedge clk_i);
  endtask

  task automatic send_start(input logic repeated);
    if (repeated) begin
      sda_drv = 1'b1;
      half_wait();
      scl_drv = 1'b1;
      half_wait();
    end
    sda_drv = 1'b0;
    half_wait();
    scl_drv = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic send_stop();
    sda_drv = 1'b0;
    half_wait();
    scl_drv = 1'b1;
    half_wait();
    sda_drv = 1'b1;
    half_wait();
  endtask

  // Line level is sampled in the middle of the SCL high phase
  task automatic clock_bit(input logic b, output logic seen);
    sda_drv = b;
    half_wait();
    scl_drv = 1'b1;
    repeat (HalfClocks / 2) @(negedge clk_i);
    seen = sda_line;
    repeat (HalfClocks / 2) @(negedge clk_i);
    scl_drv = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic send_byte(input data_byte_t b, input logic ninth, output logic ack);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], seen);
    end
    clock_bit(ninth, seen);
    ack = ~seen;
  endtask

  task automatic run_transfer(input int idx);
    int base;
    logic [7:0] mode, mask;
    addr7_t addr;
    int n, last_idx;
    logic is_i3c, end_sr, exp_ack, ack, tbit;
    logic good [MaxBytes];
    rx_entry_t e;
    base = idx * WordsPerPattern;
    mode = pat_mem[base];
    addr = pat_mem[base + 1][6:0];
    n = int'(pat_mem[base + 2]);
    mask = pat_mem[base + 7];
    is_i3c = mode[0];
    end_sr = mode[4];
    exp_ack = is_i3c ? (addr == DynAddr || addr == BCAST_ADDR) : (addr == StaticAddr);
    if (!bus_open) i3c_en_i = is_i3c;

    // Expected queue contents from the pattern
    last_idx = -1;
    for (int i = 0; i < n; i++) begin
      good[i] = exp_ack && !(is_i3c && (mask[i] || addr == BCAST_ADDR));
      if (good[i]) last_idx = i;
      if (exp_ack && is_i3c && addr != BCAST_ADDR && mask[i]) exp_perr++;
    end
    for (int i = 0; i < n; i++) begin
      if (good[i]) begin
        e.data = pat_mem[base + 3 + i];
        e.last = (i == last_idx);
        e.mode = is_i3c ? MODE_I3C : MODE_I2C;
        exp_q.push_back(e);
      end
    end

    if (bus_open) exp_rstart++;
    else exp_start++;
    send_start(bus_open);
    send_byte({addr, 1'b0}, 1'b1, ack);
    check_flag("address ack", ack, exp_ack);
    if (exp_ack) begin
      exp_addr++;
      check_addr(last_addr, {addr, 1'b0});
      for (int i = 0; i < n; i++) begin
        tbit = ~(^pat_mem[base + 3 + i]) ^ mask[i];
        send_byte(pat_mem[base + 3 + i], is_i3c ? tbit : 1'b1, ack);
        if (!is_i3c) check_flag("data ack", ack, 1'b1);
      end
    end

    if (exp_ack && end_sr) begin
      bus_open = 1'b1;
    end else begin
      send_stop();
      exp_stop++;
      bus_open = 1'b0;
      while (exp_q.size() != 0) @(negedge clk_i);
      repeat (8) @(negedge clk_i);
      check_count("bus_start_o", start_cnt, exp_start);
      check_count("bus_rstart_o", rstart_cnt, exp_rstart);
      check_count("bus_stop_o", stop_cnt, exp_stop);
      check_count("parity_err_o", perr_cnt, exp_perr);
      check_count("bus_addr_valid_o", addr_cnt, exp_addr);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Event pulses counted once each on the falling edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (arst_n_i) begin
        if (bus_start_o) start_cnt++;
        if (bus_rstart_o) rstart_cnt++;
        if (bus_stop_o) stop_cnt++;
        if (parity_err_o) perr_cnt++;
        if (bus_addr_valid_o) begin
          addr_cnt++;
          last_addr = bus_addr_o;
        end
      end
    end
  end

  // Host side of the RX queue with a random ready gap
  initial begin
    int gap;
    logic ready_next;
    gap = 0;
    forever begin
      @(negedge clk_i);
      ready_next = (gap == 0);
      if (gap > 0) gap--;
      if (arst_n_i && ready_next && rx_rvalid_o) begin
        if (exp_q.size() == 0) begin
          $display("RX queue returned an entry %h that no transfer should queue", rx_rentry_o);
          stop_on_error();
        end
        check_entry(rx_rentry_o, exp_q.pop_front());
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[17:16]);
      end
      rx_rready_i = ready_next;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: transfers did not complete within %0d ns", TimeoutNs);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    arst_n_i = 1'b0;
    scl_drv = 1'b1;
    sda_drv = 1'b1;
    i3c_en_i = 1'b0;
    static_addr_i = StaticAddr;
    dyn_addr_i = DynAddr;
    dyn_addr_valid_i = 1'b1;
    rx_rready_i = 1'b0;
    lcg_state = 32'hb6ca_4356;
    last_addr = '0;
    bus_open = 1'b0;
    start_cnt = 0;
    rstart_cnt = 0;
    stop_cnt = 0;
    perr_cnt = 0;
    addr_cnt = 0;
    exp_start = 0;
    exp_rstart = 0;
    exp_stop = 0;
    exp_perr = 0;
    exp_addr = 0;
    $readmemh("bus_patterns.hex", pat_mem);
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (4) @(negedge clk_i);
    check_flag("sda_o", sda_o, 1'b1);

    for (int p = 0; p < NumPatterns; p++) begin
      run_transfer(p);
    end
    repeat (20) @(negedge clk_i);

    if (exp_q.size() != 0) begin
      $display("%0d expected RX entries never came out of the queue", exp_q.size());
      $display("FAIL: see errors above");
      $fatal(1);
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* tb_i3c_target_assertions.sv */
// Bound assertions on SDA release at mode change, the RX read handshake and parity error pulses
`timescale 1ns/1ps

module tb_i3c_target_assertions
  import controller_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      i3c_en_i,
  input logic      sda_o,
  input logic      parity_err_o,
  input logic      rx_rvalid_o,
  input logic      rx_rready_i,
  input rx_entry_t rx_rentry_o
);

  mode_change_sda_released: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (i3c_en_i != $past(i3c_en_i)) |-> sda_o
  ) else $error("sda_o pulled low while the mode input changed");

  rx_valid_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (rx_rvalid_o && !rx_rready_i) |=> (rx_rvalid_o && rx_rentry_o == $past(rx_rentry_o))
  ) else $error("RX read entry dropped or changed before it was accepted");

  // One pulse per dropped byte, only in I3C mode
  parity_err_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    parity_err_o |-> (i3c_en_i && !$past(parity_err_o))
  ) else $error("parity_err_o pulsed outside I3C mode or for more than one cycle");

endmodule

/* i3c_target_top.sv */
// Top level: standby bus controller feeding the RX queue
`timescale 1ns/1ps

module i3c_target_top
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned RxQueueDepth = 16,
  parameter int unsigned SyncStages   = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       i3c_en_i,
  input  addr7_t     static_addr_i,
  input  addr7_t     dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  output logic       sda_o,
  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       parity_err_o,
  output logic       rx_rvalid_o,
  output rx_entry_t  rx_rentry_o,
  input  logic       rx_rready_i
);

  logic      rx_wvalid;
  logic      rx_wready;
  rx_entry_t rx_wentry;

  controller_standby #(
    .SyncStages(SyncStages)
  ) xcontroller_standby (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .i3c_en_i        (i3c_en_i),
    .static_addr_i   (static_addr_i),
    .dyn_addr_i      (dyn_addr_i),
    .dyn_addr_valid_i(dyn_addr_valid_i),
    .rx_wready_i     (rx_wready),
    .sda_o           (sda_o),
    .rx_wvalid_o     (rx_wvalid),
    .rx_wentry_o     (rx_wentry),
    .bus_start_o     (bus_start_o),
    .bus_rstart_o    (bus_rstart_o),
    .bus_stop_o      (bus_stop_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .parity_err_o    (parity_err_o)
  );

  rx_queue #(
    .RxQueueDepth(RxQueueDepth)
  ) xrx_queue (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .wvalid_i(rx_wvalid),
    .wentry_i(rx_wentry),
    .wready_o(rx_wready),
    .rvalid_o(rx_rvalid_o),
    .rentry_o(rx_rentry_o),
    .rready_i(rx_rready_i)
  );

endmodule

/* rx_queue.sv */
// RX queue: synchronous FIFO of RX entries with valid/ready on both sides
`timescale 1ns/1ps

module rx_queue
  import controller_pkg::*;
#(
  parameter int unsigned RxQueueDepth = 16
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      wvalid_i,
  input  rx_entry_t wentry_i,
  output logic      wready_o,
  output logic      rvalid_o,
  output rx_entry_t rentry_o,
  input  logic      rready_i
);

  localparam int unsigned PtrWidth = $clog2(RxQueueDepth);
  localparam int unsigned CntWidth = $clog2(RxQueueDepth + 1);

  rx_entry_t mem [RxQueueDepth];
  logic [PtrWidth-1:0] wr_ptr, rd_ptr;
  logic [CntWidth-1:0] count;
  logic push, pop;

  assign wready_o = count != CntWidth'(RxQueueDepth);
  assign rvalid_o = count != '0;
  assign rentry_o = mem[rd_ptr];
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push) wr_ptr <= (wr_ptr == PtrWidth'(RxQueueDepth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PtrWidth'(RxQueueDepth - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= wentry_i;
  end

endmodule

/* controller_standby.sv */
// Standby controller: I2C and I3C target engines muxed by bus mode
`timescale 1ns/1ps

module controller_standby
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       i3c_en_i,
  input  addr7_t     static_addr_i,
  input  addr7_t     dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  input  logic       rx_wready_i,
  output logic       sda_o,
  output logic       rx_wvalid_o,
  output rx_entry_t  rx_wentry_o,
  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       parity_err_o
);

  bus_mode_e  mode;
  logic       i2c_sda, i2c_wvalid, i2c_start, i2c_rstart, i2c_stop, i2c_addr_valid;
  logic       i3c_sda, i3c_wvalid, i3c_start, i3c_rstart, i3c_stop, i3c_addr_valid;
  logic       i3c_parity_err;
  rx_entry_t  i2c_wentry, i3c_wentry;
  logic [7:0] i2c_addr, i3c_addr;

  assign mode = i3c_en_i ? MODE_I3C : MODE_I2C;

  // Unselected engine sees no wready and its SDA is not driven out
  always_comb begin
    sda_o            = (mode == MODE_I3C) ? i3c_sda : i2c_sda;
    rx_wvalid_o      = (mode == MODE_I3C) ? i3c_wvalid : i2c_wvalid;
    rx_wentry_o      = (mode == MODE_I3C) ? i3c_wentry : i2c_wentry;
    bus_start_o      = (mode == MODE_I3C) ? i3c_start : i2c_start;
    bus_rstart_o     = (mode == MODE_I3C) ? i3c_rstart : i2c_rstart;
    bus_stop_o       = (mode == MODE_I3C) ? i3c_stop : i2c_stop;
    bus_addr_o       = (mode == MODE_I3C) ? i3c_addr : i2c_addr;
    bus_addr_valid_o = (mode == MODE_I3C) ? i3c_addr_valid : i2c_addr_valid;
    parity_err_o     = (mode == MODE_I3C) & i3c_parity_err;
  end

  i2c_target_engine #(
    .SyncStages(SyncStages)
  ) xi2c_target_engine (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .static_addr_i   (static_addr_i),
    .rx_wready_i     (rx_wready_i & (mode == MODE_I2C)),
    .sda_o           (i2c_sda),
    .rx_wvalid_o     (i2c_wvalid),
    .rx_wentry_o     (i2c_wentry),
    .bus_start_o     (i2c_start),
    .bus_rstart_o    (i2c_rstart),
    .bus_stop_o      (i2c_stop),
    .bus_addr_o      (i2c_addr),
    .bus_addr_valid_o(i2c_addr_valid)
  );

  i3c_target_engine #(
    .SyncStages(SyncStages)
  ) xi3c_target_engine (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .dyn_addr_i      (dyn_addr_i),
    .dyn_addr_valid_i(dyn_addr_valid_i),
    .rx_wready_i     (rx_wready_i & (mode == MODE_I3C)),
    .sda_o           (i3c_sda),
    .rx_wvalid_o     (i3c_wvalid),
    .rx_wentry_o     (i3c_wentry),
    .bus_start_o     (i3c_start),
    .bus_rstart_o    (i3c_rstart),
    .bus_stop_o      (i3c_stop),
    .bus_addr_o      (i3c_addr),
    .bus_addr_valid_o(i3c_addr_valid),
    .parity_err_o    (i3c_parity_err)
  );

endmodule

/* i3c_target_engine.sv */
// I3C target engine: dynamic address match, T-bit parity check, RX queue writes
`timescale 1ns/1ps

module i3c_target_engine
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  addr7_t     dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  input  logic       rx_wready_i,
  output logic       sda_o,
  output logic       rx_wvalid_o,
  output rx_entry_t  rx_wentry_o,
  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       parity_err_o
);

  bus_event_t    bus;
  engine_state_e state;
  logic [3:0]    bit_cnt;
  data_byte_t    shreg;
  data_byte_t    pend_data;
  logic pend_valid, pend_last;
  logic sda_q, bcast_q;
  logic out_free, byte_end, end_cond;
  logic is_bcast, addr_hit, tbit_rise;
  logic take_byte, push_mid, push_last;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) xbus_monitor (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .bus_o   (bus)
  );

  assign out_free = ~rx_wvalid_o | rx_wready_i;
  assign byte_end = bus.scl_fall && (bit_cnt == 4'd8);
  assign end_cond = bus.stop | bus.start | bus.rstart;

  assign is_bcast = shreg[7:1] == BCAST_ADDR;
  assign addr_hit = ~shreg[0] & (is_bcast | (dyn_addr_valid_i & (shreg[7:1] == dyn_addr_i)));

  // Nine bits with odd parity make a good byte
  assign tbit_rise = (state == DATA_ACK_OR_TBIT) && bus.scl_rise;
  assign take_byte = tbit_rise && (^{shreg, bus.sda}) && (!pend_valid || out_free);
  assign push_mid  = take_byte && pend_valid;
  assign push_last = pend_valid && (pend_last || end_cond) && out_free;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state            <= IDLE;
      bit_cnt          <= '0;
      sda_q            <= 1'b1;
      bcast_q          <= 1'b0;
      pend_valid       <= 1'b0;
      pend_last        <= 1'b0;
      rx_wvalid_o      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      parity_err_o     <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      // Bad parity and overflow both drop the byte
      parity_err_o     <= tbit_rise && !take_byte;
      if (rx_wvalid_o && rx_wready_i) rx_wvalid_o <= 1'b0;
      if (push_mid || push_last) rx_wvalid_o <= 1'b1;

      if (take_byte) pend_valid <= 1'b1;
      if (push_last) begin
        pend_valid <= 1'b0;
        pend_last  <= 1'b0;
      end else if (pend_valid && end_cond) begin
        pend_last <= 1'b1;
      end

      if (bus.stop) begin
        state <= IDLE;
        sda_q <= 1'b1;
      end else if (bus.start || bus.rstart) begin
        state   <= ADDR;
        bit_cnt <= '0;
        sda_q   <= 1'b1;
      end else begin
        case (state)
          ADDR: begin
            if (bus.scl_rise) bit_cnt <= bit_cnt + 4'd1;
            if (byte_end) begin
              state            <= addr_hit ? ADDR_ACK : IGNORE;
              sda_q            <= ~addr_hit;
              bus_addr_valid_o <= addr_hit;
              bcast_q          <= is_bcast;
            end
          end
          ADDR_ACK: begin
            if (bus.scl_fall) begin
              state   <= bcast_q ? IGNORE : DATA;
              sda_q   <= 1'b1;
              bit_cnt <= '0;
            end
          end
          DATA: begin
            if (bus.scl_rise) bit_cnt <= bit_cnt + 4'd1;
            if (byte_end) state <= DATA_ACK_OR_TBIT;
          end
          DATA_ACK_OR_TBIT: begin
            if (bus.scl_fall) begin
              state   <= DATA;
              bit_cnt <= '0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.scl_rise) shreg <= {shreg[6:0], bus.sda};
    if (state == ADDR && byte_end) bus_addr_o <= shreg;
    if (take_byte) pend_data <= shreg;
    if (push_mid || push_last) begin
      rx_wentry_o <= '{data: pend_data, last: push_last, mode: MODE_I3C};
    end
  end

  assign sda_o        = sda_q;
  assign bus_start_o  = bus.start;
  assign bus_rstart_o = bus.rstart;
  assign bus_stop_o   = bus.stop;

endmodule

/* i2c_target_engine.sv */
// I2C target engine: static address match, ACK, byte assembly, RX queue writes
`timescale 1ns/1ps

module i2c_target_engine
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  addr7_t     static_addr_i,
  input  logic       rx_wready_i,
  output logic       sda_o,
  output logic       rx_wvalid_o,
  output rx_entry_t  rx_wentry_o,
  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o
);

  bus_event_t    bus;
  engine_state_e state;
  logic [3:0]    bit_cnt;
  data_byte_t    shreg;
  data_byte_t    pend_data;
  logic pend_valid, pend_last;
  logic sda_q;
  logic out_free, byte_end, end_cond;
  logic take_byte, push_mid, push_last;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) xbus_monitor (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .bus_o   (bus)
  );

  assign out_free = ~rx_wvalid_o | rx_wready_i;
  assign byte_end = bus.scl_fall && (bit_cnt == 4'd8);
  assign end_cond = bus.stop | bus.start | bus.rstart;

  // A byte waits in pend until its successor or the end condition
  assign take_byte = byte_end && (state == DATA) && (!pend_valid || out_free);
  assign push_mid  = take_byte && pend_valid;
  assign push_last = pend_valid && (pend_last || end_cond) && out_free;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state            <= IDLE;
      bit_cnt          <= '0;
      sda_q            <= 1'b1;
      pend_valid       <= 1'b0;
      pend_last        <= 1'b0;
      rx_wvalid_o      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      if (rx_wvalid_o && rx_wready_i) rx_wvalid_o <= 1'b0;
      if (push_mid || push_last) rx_wvalid_o <= 1'b1;

      if (take_byte) pend_valid <= 1'b1;
      if (push_last) begin
        pend_valid <= 1'b0;
        pend_last  <= 1'b0;
      end else if (pend_valid && end_cond) begin
        pend_last <= 1'b1;
      end

      if (bus.stop) begin
        state <= IDLE;
        sda_q <= 1'b1;
      end else if (bus.start || bus.rstart) begin
        state   <= ADDR;
        bit_cnt <= '0;
        sda_q   <= 1'b1;
      end else begin
        case (state)
          ADDR, DATA: begin
            if (bus.scl_rise) bit_cnt <= bit_cnt + 4'd1;
            if (byte_end && state == DATA) begin
              // NACK when the queue cannot take the previous byte
              state <= DATA_ACK_OR_TBIT;
              sda_q <= ~take_byte;
            end else if (byte_end && shreg == {static_addr_i, 1'b0}) begin
              state            <= ADDR_ACK;
              sda_q            <= 1'b0;
              bus_addr_valid_o <= 1'b1;
            end else if (byte_end) begin
              state <= IGNORE;
            end
          end
          ADDR_ACK, DATA_ACK_OR_TBIT: begin
            if (bus.scl_fall) begin
              state   <= (state == DATA_ACK_OR_TBIT && sda_q) ? IGNORE : DATA;
              sda_q   <= 1'b1;
              bit_cnt <= '0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.scl_rise) shreg <= {shreg[6:0], bus.sda};
    if (state == ADDR && byte_end) bus_addr_o <= shreg;
    if (take_byte) pend_data <= shreg;
    if (push_mid || push_last) begin
      rx_wentry_o <= '{data: pend_data, last: push_last, mode: MODE_I2C};
    end
  end

  assign sda_o        = sda_q;
  assign bus_start_o  = bus.start;
  assign bus_rstart_o = bus.rstart;
  assign bus_stop_o   = bus.stop;

endmodule

/* bus_monitor.sv */
// Bus monitor: SCL/SDA synchronizer, START/Sr/STOP and SCL edge detection
`timescale 1ns/1ps

module bus_monitor
  import i3c_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t bus_o
);

  // Top bit holds the previous synchronized level
  logic [SyncStages:0] scl_q;
  logic [SyncStages:0] sda_q;
  logic scl_s, scl_p;
  logic sda_s, sda_p;
  logic start_det;
  logic stop_det;
  logic busy;

  assign scl_s = scl_q[SyncStages-1];
  assign scl_p = scl_q[SyncStages];
  assign sda_s = sda_q[SyncStages-1];
  assign sda_p = sda_q[SyncStages];

  // Conditions only count while SCL stays high
  assign start_det = scl_s & scl_p & sda_p & ~sda_s;
  assign stop_det  = scl_s & scl_p & ~sda_p & sda_s;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_q <= '1;
      sda_q <= '1;
      busy  <= 1'b0;
      bus_o <= '{sda: 1'b1, default: 1'b0};
    end else begin
      scl_q <= {scl_q[SyncStages-1:0], scl_i};
      sda_q <= {sda_q[SyncStages-1:0], sda_i};

      if (start_det) begin
        busy <= 1'b1;
      end else if (stop_det) begin
        busy <= 1'b0;
      end

      bus_o.start    <= start_det & ~busy;
      bus_o.rstart   <= start_det & busy;
      bus_o.stop     <= stop_det;
      bus_o.scl_rise <= scl_s & ~scl_p;
      bus_o.scl_fall <= ~scl_s & scl_p;
      bus_o.sda      <= sda_s;
    end
  end

endmodule

/* controller_pkg.sv */
// Target queue entry, bus mode and engine FSM state types

package controller_pkg;

  import i3c_pkg::*;

  typedef enum logic {
    MODE_I2C = 1'b0,
    MODE_I3C = 1'b1
  } bus_mode_e;

  // Last is set on the byte that ended with STOP or repeated START
  typedef struct packed {
    data_byte_t data;
    logic       last;
    bus_mode_e  mode;
  } rx_entry_t;

  // Shared by both target engines
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    DATA,
    DATA_ACK_OR_TBIT,
    IGNORE
  } engine_state_e;

endpackage

/* i3c_pkg.sv */
// Bus-level types: address, data byte, bus event flags, broadcast address

package i3c_pkg;

  // 7-bit target address as seen on the bus
  typedef logic [6:0] addr7_t;

  // One data byte on SDA, MSB first
  typedef logic [7:0] data_byte_t;

  // Single-cycle condition flags plus the synchronized SDA level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  // I3C broadcast address
  localparam addr7_t BCAST_ADDR = 7'h7E;

endpackage
